// ==== tests/core_patterns.txt ====
// Columns, all hex: kind a b c d. Kind 1 is a program word (a = address, b = word).
// Kind 2 is an expected retire (a = pc, b = wen, c = rd, d = data); unused columns are 0.
// Straight line setup.
1 00 1205 0 0  // ADDI r1, r0, 5
1 01 143d 0 0  // ADDI r2, r0, -3
1 02 2440 0 0  // ADD  r2, r1
1 03 1603 0 0  // ADDI r3, r0, 3
// Backward loop, three passes, exit mispredicts.
1 04 2840 0 0  // ADD  r4, r1
1 05 16ff 0 0  // ADDI r3, r3, -1
1 06 30fe 0 0  // BNEZ r3, -2
// Forward taken branch over two wrong path words.
1 07 1a01 0 0  // ADDI r5, r0, 1
1 08 3143 0 0  // BNEZ r5, +3
1 09 1c1f 0 0  // ADDI r6, r0, 31 (skipped)
1 0a 1c1e 0 0  // ADDI r6, r0, 30 (skipped)
// Register jump to 14, fall through squashed, including a HALT.
1 0b 1e14 0 0  // ADDI r7, r0, 20
1 0c 41c0 0 0  // JR   r7
1 0d 1c1d 0 0  // ADDI r6, r0, 29 (skipped)
1 0e 5000 0 0  // HALT (skipped)
1 14 2d00 0 0  // ADD  r6, r4
1 15 2d80 0 0  // ADD  r6, r6
1 16 0000 0 0  // NOP
1 17 13a0 0 0  // ADDI r1, r6, -32
1 18 5000 0 0  // HALT
1 19 1401 0 0  // ADDI r2, r0, 1 (never retires)
// Expected retire stream.
2 00 1 1 0005
2 01 1 2 fffd
2 02 1 2 0002
2 03 1 3 0003
2 04 1 4 0005
2 05 1 3 0002
2 06 0 0 0000
2 04 1 4 000a
2 05 1 3 0001
2 06 0 0 0000
2 04 1 4 000f
2 05 1 3 0000
2 06 0 0 0000
2 07 1 5 0001
2 08 0 0 0000
2 0b 1 7 0014
2 0c 0 0 0000
2 14 1 6 000f
2 15 1 6 001e
2 16 0 0 0000
2 17 1 1 fffe
2 18 0 0 0000

// ==== vlog.f ====
+incdir+src
src/core_pkg.sv
src/pc_gen.sv
src/front_end.sv
src/instr_fifo.sv
src/back_end.sv
src/rift_core.sv
tests/tb_imem.sv
tests/tb_core.sv

// ==== Makefile ====
# Verilator flow for the core and its testbench.

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module rift_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_core -o sim_tb
	-./obj_dir/sim_tb > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_core.sv ====
// ##################################################
// Core testbench.
// Runs the pattern program and checks every retire.
// ##################################################

`timescale 1ns/1ps

`include "core_config.svh"

module tb_core;

	localparam int COLS              = 5;
	localparam int MAX_ROWS          = 96;
	localparam int CYCLES_PER_RETIRE = 60;

	logic                  CLK;
	logic                  arst_n;
	logic                  imem_req_valid;
	logic                  imem_req_ready;
	logic [`CORE_PCW-1:0]  imem_req_addr;
	logic                  imem_rsp_valid;
	logic [`CORE_ILEN-1:0] imem_rsp_data;
	logic                  retire_valid;
	logic [`CORE_PCW-1:0]  retire_pc;
	logic                  retire_wen;
	logic [2:0]            retire_rd;
	logic [`CORE_XLEN-1:0] retire_data;
	logic                  halted;

	logic [15:0] rows [0:COLS*MAX_ROWS-1];
	logic [15:0] exp_pc   [$];
	logic [15:0] exp_wen  [$];
	logic [15:0] exp_rd   [$];
	logic [15:0] exp_data [$];
	int          n_exp = 0;
	int          seen  = 0;

	rift_core uut (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.imem_req_valid (imem_req_valid),
		.imem_req_ready (imem_req_ready),
		.imem_req_addr  (imem_req_addr),
		.imem_rsp_valid (imem_rsp_valid),
		.imem_rsp_data  (imem_rsp_data),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_wen     (retire_wen),
		.retire_rd      (retire_rd),
		.retire_data    (retire_data),
		.halted         (halted)
	);

	tb_imem u_imem (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.req_valid (imem_req_valid),
		.req_ready (imem_req_ready),
		.req_addr  (imem_req_addr),
		.rsp_valid (imem_rsp_valid),
		.rsp_data  (imem_rsp_data)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h at retire %0d",
				name, got, expected, seen);
			stop_run();
		end
	endtask

	// Kind 2 rows hold the expected retire stream in order.
	task automatic load_expected();
		for (int i = 0; i < COLS*MAX_ROWS; i++) begin
			rows[i] = '1;
		end
		$readmemh("tests/core_patterns.txt", rows);
		for (int r = 0; r < MAX_ROWS; r++) begin
			if (rows[r*COLS] == 16'h0002) begin
				exp_pc.push_back(rows[r*COLS+1]);
				exp_wen.push_back(rows[r*COLS+2]);
				exp_rd.push_back(rows[r*COLS+3]);
				exp_data.push_back(rows[r*COLS+4]);
			end
		end
		n_exp = exp_pc.size();
		if (n_exp == 0) begin
			$display("no expected retire rows were found in the pattern file");
			stop_run();
		end
	endtask

	initial begin
		arst_n = 1'b0;
		load_expected();
		repeat (8) @(posedge CLK);
		#2;
		arst_n = 1'b1;
		wait (seen == n_exp);
		// Leave room for a stray retire after the last expected one.
		repeat (10) @(negedge CLK);
		if (!halted) begin
			$display("halted is still low after the last expected retire");
			stop_run();
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

	// Retire outputs are registered, so mid cycle they are settled.
	initial begin
		@(posedge arst_n);
		forever begin
			@(negedge CLK);
			if (retire_valid) begin
				if (seen >= n_exp) begin
					$display("an extra retire at pc 0x%0h came after the expected stream",
						retire_pc);
					stop_run();
				end else begin
					check_value("retire_pc", 32'(retire_pc), 32'(exp_pc[seen]));
					check_value("retire_wen", 32'(retire_wen), 32'(exp_wen[seen]));
					if (exp_wen[seen] != 16'h0) begin
						check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[seen]));
						check_value("retire_data", 32'(retire_data), 32'(exp_data[seen]));
					end
					seen++;
				end
			end
		end
	end

	initial begin
		@(posedge arst_n);
		repeat (n_exp * CYCLES_PER_RETIRE) @(posedge CLK);
		$display("timeout: %0d of %0d expected retires seen after %0d cycles",
			seen, n_exp, n_exp * CYCLES_PER_RETIRE);
		stop_run();
	end

endmodule

// ==== tests/tb_imem.sv ====
// ##################################################
// Instruction memory model.
// Random request stalls and 1 to 3 cycle responses.
// ##################################################

`timescale 1ns/1ps

`include "core_config.svh"

module tb_imem (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  logic [`CORE_PCW-1:0]  req_addr,
	output logic                  rsp_valid,
	output logic [`CORE_ILEN-1:0] rsp_data
);

	localparam int COLS     = 5;
	localparam int MAX_ROWS = 96;

	logic [`CORE_ILEN-1:0] mem  [0:(2**`CORE_PCW)-1];
	logic [15:0]           rows [0:COLS*MAX_ROWS-1];

	task automatic load_program();
		for (int a = 0; a < 2**`CORE_PCW; a++) begin
			// Words outside the program are NOPs tagged with their address.
			mem[a] = {core_pkg::OP_NOP, 12'(a)};
		end
		for (int i = 0; i < COLS*MAX_ROWS; i++) begin
			rows[i] = '1;
		end
		$readmemh("tests/core_patterns.txt", rows);
		for (int r = 0; r < MAX_ROWS; r++) begin
			if (rows[r*COLS] == 16'h0001) begin
				mem[rows[r*COLS+1][`CORE_PCW-1:0]] = rows[r*COLS+2];
			end
		end
	endtask

	initial begin
		logic                 take;
		logic                 pending;
		logic [`CORE_PCW-1:0] take_addr;
		logic [`CORE_PCW-1:0] rsp_addr;
		int                   delay;
		// Single seed for every random choice in the run.
		void'($urandom(35927));
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp_data  = '0;
		pending   = 1'b0;
		rsp_addr  = '0;
		delay     = 0;
		load_program();
		@(posedge arst_n);
		forever begin
			// The handshake seen mid cycle is the one taken at the next edge.
			@(negedge CLK);
			take      = req_valid && req_ready;
			take_addr = req_addr;
			@(posedge CLK);
			#2;
			rsp_valid = 1'b0;
			if (take) begin
				pending  = 1'b1;
				rsp_addr = take_addr;
				delay    = $urandom_range(2, 0);
			end
			if (pending) begin
				if (delay == 0) begin
					rsp_valid = 1'b1;
					rsp_data  = mem[rsp_addr];
					pending   = 1'b0;
				end else begin
					delay--;
				end
			end
			// About one cycle in three stalls the request.
			req_ready = ($urandom_range(2, 0) != 0);
		end
	end

endmodule

// ==== src/rift_core.sv ====
// ##################################################
// Core top level.
// Front end, instruction FIFO and back end.
// ##################################################

`timescale 1ns/1ps

`include "core_config.svh"

module rift_core (
	input  logic                  CLK,
	input  logic                  arst_n,
	output logic                  imem_req_valid,
	input  logic                  imem_req_ready,
	output logic [`CORE_PCW-1:0]  imem_req_addr,
	input  logic                  imem_rsp_valid,
	input  logic [`CORE_ILEN-1:0] imem_rsp_data,
	output logic                  retire_valid,
	output logic [`CORE_PCW-1:0]  retire_pc,
	output logic                  retire_wen,
	output logic [2:0]            retire_rd,
	output logic [`CORE_XLEN-1:0] retire_data,
	output logic                  halted
);

	logic                     fifo_push;
	logic [`CORE_FIFO_DW-1:0] fifo_din;
	logic                     fifo_full;
	logic                     fifo_pop;
	logic [`CORE_FIFO_DW-1:0] fifo_dout;
	logic                     fifo_empty;
	logic                     flush;
	logic [`CORE_PCW-1:0]     redirect_pc;

	front_end u_front_end (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.imem_req_valid (imem_req_valid),
		.imem_req_ready (imem_req_ready),
		.imem_req_addr  (imem_req_addr),
		.imem_rsp_valid (imem_rsp_valid),
		.imem_rsp_data  (imem_rsp_data),
		.fifo_push      (fifo_push),
		.fifo_full      (fifo_full),
		.fifo_din       (fifo_din),
		.flush          (flush),
		.redirect_pc    (redirect_pc)
	);

	instr_fifo #(
		.DW (`CORE_FIFO_DW),
		.AW (`CORE_FIFO_AW)
	) u_instr_fifo (
		.CLK    (CLK),
		.arst_n (arst_n),
		.push   (fifo_push),
		.din    (fifo_din),
		.full   (fifo_full),
		.pop    (fifo_pop),
		.dout   (fifo_dout),
		.empty  (fifo_empty),
		.flush  (flush)
	);

	back_end u_back_end (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.fifo_pop     (fifo_pop),
		.fifo_empty   (fifo_empty),
		.fifo_dout    (fifo_dout),
		.flush        (flush),
		.redirect_pc  (redirect_pc),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_wen   (retire_wen),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data),
		.halted       (halted)
	);

endmodule

// ==== src/back_end.sv ====
// ##################################################
// Back end.
// Executes FIFO entries on an 8-entry register file,
// resolves branches and reports each retire.
// ##################################################

`timescale 1ns/1ps

`include "core_config.svh"

module back_end (
	input  logic                     CLK,
	input  logic                     arst_n,
	output logic                     fifo_pop,
	input  logic                     fifo_empty,
	input  logic [`CORE_FIFO_DW-1:0] fifo_dout,
	output logic                     flush,
	output logic [`CORE_PCW-1:0]     redirect_pc,
	output logic                     retire_valid,
	output logic [`CORE_PCW-1:0]     retire_pc,
	output logic                     retire_wen,
	output logic [2:0]               retire_rd,
	output logic [`CORE_XLEN-1:0]    retire_data,
	output logic                     halted
);

	logic [`CORE_XLEN-1:0] regs [0:7];

	logic [`CORE_ILEN-1:0] instr;
	logic [`CORE_PCW-1:0]  cur_pc;
	logic [`CORE_PCW-1:0]  pred_pc;
	logic [`CORE_PCW-1:0]  actual_pc;
	logic [`CORE_PCW-1:0]  branch_pc;
	core_pkg::opcode_e     opcode;
	logic [2:0]            rd;
	logic [2:0]            rs;
	logic [`CORE_XLEN-1:0] imm_ext;
	logic [`CORE_XLEN-1:0] rs_val;
	logic [`CORE_XLEN-1:0] rd_val;
	logic [`CORE_XLEN-1:0] result;
	logic                  wen;
	logic                  mispredict;

	// Entry layout from the front end: instruction, PC, predicted next PC.
	assign {instr, cur_pc, pred_pc} = fifo_dout;

	assign opcode  = core_pkg::opcode_e'(instr[15:12]);
	assign rd      = instr[11:9];
	assign rs      = instr[8:6];
	assign imm_ext = {{(`CORE_XLEN-6){instr[5]}}, instr[5:0]};
	assign rs_val  = regs[rs];
	assign rd_val  = regs[rd];

	assign branch_pc = cur_pc + imm_ext[`CORE_PCW-1:0];

	// Nothing issues while a flush is draining the wrong path.
	assign fifo_pop = !fifo_empty && !flush && !halted;

	always_comb begin
		wen       = 1'b0;
		result    = '0;
		actual_pc = cur_pc + 1'b1;
		case (opcode)
			core_pkg::OP_ADDI: begin
				wen    = 1'b1;
				result = rs_val + imm_ext;
			end
			core_pkg::OP_ADD: begin
				wen    = 1'b1;
				result = rd_val + rs_val;
			end
			core_pkg::OP_BNEZ: begin
				if (rs_val != '0) begin
					actual_pc = branch_pc;
				end
			end
			core_pkg::OP_JR: begin
				actual_pc = rs_val[`CORE_PCW-1:0];
			end
			default: begin
				// NOP, HALT and unused opcodes just fall through.
			end
		endcase
	end

	assign mispredict = fifo_pop && (actual_pc != pred_pc);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (fifo_pop && wen) begin
			regs[rd] <= result;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid <= 1'b0;
			flush        <= 1'b0;
			halted       <= 1'b0;
		end else begin
			retire_valid <= fifo_pop;
			flush        <= mispredict;
			if (fifo_pop && opcode == core_pkg::OP_HALT) begin
				halted <= 1'b1;
			end
		end
	end

	// Retire fields are only meaningful with retire_valid.
	always_ff @(posedge CLK) begin
		if (fifo_pop) begin
			retire_pc   <= cur_pc;
			retire_wen  <= wen;
			retire_rd   <= wen ? rd : 3'd0;
			retire_data <= result;
		end
		if (mispredict) begin
			redirect_pc <= actual_pc;
		end
	end

	a_flush_pulse: assert property (@(posedge CLK) disable iff (!arst_n) flush |=> !flush);

endmodule

// ==== src/instr_fifo.sv ====
// ##################################################
// Instruction FIFO.
// Circular buffer, first word fall through, flushable.
// ##################################################

`timescale 1ns/1ps

module instr_fifo #(
	parameter int DW = 32,
	parameter int AW = 3
) (
	input  logic          CLK,
	input  logic          arst_n,
	input  logic          push,
	input  logic [DW-1:0] din,
	output logic          full,
	input  logic          pop,
	output logic [DW-1:0] dout,
	output logic          empty,
	input  logic          flush
);

	logic [DW-1:0] mem [0:(2**AW)-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign full  = count == (AW+1)'(2**AW);
	assign empty = count == '0;
	assign dout  = mem[rd_ptr];

	// Pushes when full are rejected, and flush discards everything in the same cycle.
	assign do_push = push && !full && !flush;
	assign do_pop  = pop && !empty && !flush;

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
		end
	end

	a_no_push_full: assert property (@(posedge CLK) disable iff (!arst_n) push |-> !full);
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (!arst_n) pop |-> !empty);

endmodule

// ==== src/front_end.sv ====
// ##################################################
// Front end.
// Fetches one word at a time, predicts the next PC
// and pushes entries into the instruction FIFO.
// ##################################################

`timescale 1ns/1ps

`include "core_config.svh"

module front_end (
	input  logic                     CLK,
	input  logic                     arst_n,
	output logic                     imem_req_valid,
	input  logic                     imem_req_ready,
	output logic [`CORE_PCW-1:0]     imem_req_addr,
	input  logic                     imem_rsp_valid,
	input  logic [`CORE_ILEN-1:0]    imem_rsp_data,
	output logic                     fifo_push,
	input  logic                     fifo_full,
	output logic [`CORE_FIFO_DW-1:0] fifo_din,
	input  logic                     flush,
	input  logic [`CORE_PCW-1:0]     redirect_pc
);

	core_pkg::fetch_state_e state;

	logic                 req_valid_q;
	logic                 req_stale_q;
	logic [`CORE_PCW-1:0] req_addr_q;
	logic                 halt_seen;
	logic                 issue;
	logic                 rsp_accept;
	logic                 rsp_is_halt;
	logic [`CORE_PCW-1:0] pc;
	logic [`CORE_PCW-1:0] next_pc;

	pc_gen u_pc_gen (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.advance     (rsp_accept),
		.instr       (imem_rsp_data),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.next_pc     (next_pc)
	);

	// The request is held in flops so that a flush cannot move it.
	assign imem_req_valid = req_valid_q;
	assign imem_req_addr  = req_addr_q;

	// At most one fetch is in flight, so a free slot at issue time is still free
	// when the response arrives.
	assign issue = (state == core_pkg::FETCH_IDLE) && !req_valid_q && !fifo_full
		&& !halt_seen && !flush;

	assign rsp_accept  = (state == core_pkg::FETCH_WAIT) && imem_rsp_valid && !flush;
	assign rsp_is_halt = core_pkg::opcode_e'(imem_rsp_data[15:12]) == core_pkg::OP_HALT;

	// While waiting, pc still equals the address that was fetched.
	assign fifo_push = rsp_accept;
	assign fifo_din  = {imem_rsp_data, pc, next_pc};

	always_ff @(posedge CLK) begin
		if (issue) begin
			req_addr_q <= pc;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state       <= core_pkg::FETCH_IDLE;
			req_valid_q <= 1'b0;
			req_stale_q <= 1'b0;
			halt_seen   <= 1'b0;
		end else begin
			case (state)
				core_pkg::FETCH_IDLE: begin
					if (issue) begin
						req_valid_q <= 1'b1;
					end else if (req_valid_q && imem_req_ready) begin
						req_valid_q <= 1'b0;
						req_stale_q <= 1'b0;
						// A request flushed before acceptance still gets a response.
						if (flush || req_stale_q) begin
							state <= core_pkg::FETCH_DROP;
						end else begin
							state <= core_pkg::FETCH_WAIT;
						end
					end else if (req_valid_q && flush) begin
						req_stale_q <= 1'b1;
					end
				end
				core_pkg::FETCH_WAIT: begin
					if (imem_rsp_valid) begin
						state <= core_pkg::FETCH_IDLE;
					end else if (flush) begin
						state <= core_pkg::FETCH_DROP;
					end
				end
				core_pkg::FETCH_DROP: begin
					if (imem_rsp_valid) begin
						state <= core_pkg::FETCH_IDLE;
					end
				end
				default: begin
					state <= core_pkg::FETCH_IDLE;
				end
			endcase

			// Fetch stops after a HALT until the back end redirects.
			if (flush) begin
				halt_seen <= 1'b0;
			end else if (rsp_accept && rsp_is_halt) begin
				halt_seen <= 1'b1;
			end
		end
	end

	// A stalled request keeps its valid and address until memory takes it.
	a_req_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req_addr));

endmodule

// ==== src/pc_gen.sv ====
// ##################################################
// Fetch PC generator.
// Static prediction: backward BNEZ taken, else +1.
// ##################################################

`timescale 1ns/1ps

`include "core_config.svh"

module pc_gen (
	input  logic                  CLK,
	input  logic                  arst_n,
	input  logic                  advance,
	input  logic [`CORE_ILEN-1:0] instr,
	input  logic                  flush,
	input  logic [`CORE_PCW-1:0]  redirect_pc,
	output logic [`CORE_PCW-1:0]  pc,
	output logic [`CORE_PCW-1:0]  next_pc
);

	logic [`CORE_PCW-1:0] imm_ext;
	logic                 is_bnez;
	logic                 backward;

	// The immediate is a signed word offset.
	assign imm_ext = {{(`CORE_PCW-6){instr[5]}}, instr[5:0]};

	assign is_bnez  = core_pkg::opcode_e'(instr[15:12]) == core_pkg::OP_BNEZ;
	assign backward = instr[5];

	// Loops branch backwards, so those are guessed taken.
	// JR targets are unknown here and fall through like anything else.
	always_comb begin
		if (is_bnez && backward) begin
			next_pc = pc + imm_ext;
		end else begin
			next_pc = pc + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (flush) begin
			// A redirect from the back end wins over a new fetch.
			pc <= redirect_pc;
		end else if (advance) begin
			pc <= next_pc;
		end
	end

endmodule

// ==== src/core_pkg.sv ====
// ##################################################
// Core package.
// Opcode and fetch sequencer state encodings.
// ##################################################

package core_pkg;

	// Opcode field, instruction bits 15:12.
	// Remaining fields are rd in 11:9, rs in 8:6 and a signed
	// 6-bit immediate in 5:0.
	typedef enum logic [3:0] {
		// No operation.
		OP_NOP  = 4'h0,
		// rd = rs + sext(imm).
		OP_ADDI = 4'h1,
		// rd = rd + rs.
		OP_ADD  = 4'h2,
		// If rs is nonzero the PC moves by sext(imm).
		OP_BNEZ = 4'h3,
		// PC takes the low bits of rs.
		OP_JR   = 4'h4,
		// Stops the core once it retires.
		OP_HALT = 4'h5
	} opcode_e;

	// Fetch sequencer states.
	// FETCH_DROP waits for a response that a flush made stale.
	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0,
		FETCH_WAIT = 2'd1,
		FETCH_DROP = 2'd2
	} fetch_state_e;

endpackage

// ==== src/core_config.svh ====
// ##################################################
// Core configuration.
// Widths shared by the front end, FIFO and back end.
// ##################################################

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Register data width.
`define CORE_XLEN 16
// PC width, counted in instruction words.
`define CORE_PCW 8
// Instruction width.
`define CORE_ILEN 16

// Instruction FIFO depth is 2**CORE_FIFO_AW entries.
`define CORE_FIFO_AW 3
// Entry holds instruction, PC and predicted next PC.
`define CORE_FIFO_DW 32

`endif
